// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
LINTFLAGS := --lint-only --timing -Wall
TOP       := basic_organ_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
PASS_MSG  := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/basic_organ_tb.sv
`timescale 1ns/1ps
`default_nettype none

module basic_organ_tb;

  import organ_pkg::*;

  localparam int REPEAT_CYCLES = 200;
  localparam int HOLD_CYCLES   = 50;

  localparam int KEY_UP    = 0;
  localparam int KEY_DOWN  = 1;
  localparam int KEY_CLEAR = 2;

  localparam int UP_TESTS   = 3;
  localparam int DOWN_TESTS = 3;
  localparam int SAT_STEPS  = 260;
  localparam int NUM_NOTES  = 4;
  localparam int MAX_HALF   = 47801;
  localparam int TONE_LIMIT = 2 * MAX_HALF + 4;

  // Worst case length of each phase in clock cycles
  localparam int CHECK_CYCLES = HOLD_CYCLES + 8;
  localparam int TEST_CYCLES  = 3 + CHECK_CYCLES
    + (UP_TESTS + DOWN_TESTS) * (5 * REPEAT_CYCLES + CHECK_CYCLES)
    + 2 * (SAT_STEPS * REPEAT_CYCLES + CHECK_CYCLES)
    + (5 + CHECK_CYCLES)
    + NUM_NOTES * (2 + 3 * TONE_LIMIT)
    + (4 + 2 * MAX_HALF);
  localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;

  // Bit n of each mask is set when hex digit n lights the segment (g down to a)
  localparam logic [SEG_W-1:0][15:0] LIT_MASK = {
    16'hEF7C, 16'hDF71, 16'hFD45, 16'h7B6D, 16'h2FFB, 16'h279F, 16'hD7ED
  };

  logic                               CLK_50M;
  logic                               rst_n;
  logic [2:0]                         key;
  logic [3:0]                         sw;
  logic [NUM_DIGITS-1:0][SEG_W-1:0]   hex_segments;
  logic [SAMPLE_W-1:0]                audio_sample;

  logic [31:0] lfsr_state = 32'hf2b7_3fda;
  logic        check_pending = 1'b0;
  int          check_failures = 0;
  // Holds +1 per up step, -1 per down step and 0 per clear
  int          step_log [$];

  basic_organ #(
    .REPEAT_CYCLES(REPEAT_CYCLES),
    .HOLD_CYCLES  (HOLD_CYCLES)
  ) DUT (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .key          (key),
    .sw           (sw),
    .hex_segments (hex_segments),
    .audio_sample (audio_sample)
  );

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // ==============================
  // Reference models
  // ==============================
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // Replays the step log with saturation at both ends
  function automatic int expected_count();
    int offset;
    offset = 0;
    foreach (step_log[i])
    begin
      if (step_log[i] == 0)
        offset = 0;
      else if (step_log[i] > 0)
        offset = (offset + SPEED_STEP > MAX_OFFSET) ? MAX_OFFSET : offset + SPEED_STEP;
      else
        offset = (offset - SPEED_STEP < -MAX_OFFSET) ? -MAX_OFFSET : offset - SPEED_STEP;
    end
    return DEFAULT_COUNT + offset;
  endfunction

  function automatic logic [NUM_DIGITS-1:0][SEG_W-1:0] segments_for(int count);
    logic [NUM_DIGITS-1:0][SEG_W-1:0] segs;
    logic [3:0]                       nib;
    for (int d = 0; d < NUM_DIGITS; d++)
    begin
      nib = 4'((count >> (4 * d)) & 15);
      // Active low
      for (int s = 0; s < SEG_W; s++)
        segs[d][s] = ~LIT_MASK[s][nib];
    end
    return segs;
  endfunction

  function automatic int expected_half(int idx);
    case (idx)
      0:       return 47801;
      1:       return 42589;
      2:       return 37936;
      3:       return 35816;
      4:       return 31888;
      5:       return 28409;
      6:       return 25303;
      default: return 23900;
    endcase
  endfunction

  // ==============================
  // Helper tasks
  // ==============================
  task automatic stop_on_failure(input string what);
    check_failures++;
    $display("%s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic take_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      value = (value << 1) | int'(lfsr_state[0]);
    end
  endtask

  // Key is sampled low on exactly `cycles` rising edges
  task automatic hold_key(input int idx, input int cycles);
    @(posedge CLK_50M);
    key <= ~(3'b001 << idx);
    repeat (cycles) @(posedge CLK_50M);
    key <= 3'b111;
  endtask

  task automatic log_steps(input int dir, input int n);
    for (int i = 0; i < n; i++)
      step_log.push_back(dir);
  endtask

  task automatic request_check();
    check_pending = 1'b1;
    wait (!check_pending);
  endtask

  // Starts at a falling edge and returns at the falling edge that shows the change
  task automatic wait_for_toggle(output int cycles);
    logic [SAMPLE_W-1:0] start;
    start  = audio_sample;
    cycles = 0;
    while (audio_sample == start && cycles <= TONE_LIMIT)
    begin
      @(negedge CLK_50M);
      cycles++;
    end
    assert (audio_sample != start)
    else stop_on_failure($sformatf("The tone stopped toggling, audio_sample stuck at %h", start));
    assert (audio_sample == ((start == 8'h80) ? 8'h7F : 8'h80))
    else stop_on_failure($sformatf("ERROR at %0t: audio_sample went from %h to %h",
                                   $time, start, audio_sample));
  endtask

  task automatic check_note(input int idx);
    int cycles;
    @(posedge CLK_50M);
    sw <= {3'(idx), 1'b1};
    @(negedge CLK_50M);
    // First change follows the restart and is not a full period
    wait_for_toggle(cycles);
    for (int i = 0; i < 2; i++)
    begin
      wait_for_toggle(cycles);
      assert (cycles == expected_half(idx))
      else stop_on_failure($sformatf("ERROR at %0t: note %0d half period %0d, expected %0d",
                                     $time, idx, cycles, expected_half(idx)));
    end
  endtask

  // ==============================
  // Display checker
  // ==============================
  initial
  begin : display_checker
    int                               exp_count;
    logic [NUM_DIGITS-1:0][SEG_W-1:0] exp_segs;
    forever
    begin
      wait (check_pending);
      repeat (HOLD_CYCLES + 4) @(posedge CLK_50M);
      @(negedge CLK_50M);
      exp_count = expected_count();
      exp_segs  = segments_for(exp_count);
      assert (hex_segments == exp_segs)
      else stop_on_failure($sformatf("ERROR at %0t: display %h, expected %h for count %0d",
                                     $time, hex_segments, exp_segs, exp_count));
      check_pending = 1'b0;
    end
  end

  initial
  begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge CLK_50M);
    $display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped by the watchdog");
  end

  // ==============================
  // Stimulus
  // ==============================
  initial
  begin : main
    int pick;
    int k;
    $timeformat(-9, 0, " ns", 0);
    rst_n = 1'b0;
    key   = 3'b111;
    sw    = 4'h0;
    repeat (3) @(posedge CLK_50M);
    rst_n <= 1'b1;

    // Reset state
    request_check();
    @(negedge CLK_50M);
    assert (audio_sample == 8'h80)
    else stop_on_failure($sformatf("ERROR at %0t: audio_sample %h after reset, expected 80",
                                   $time, audio_sample));

    for (int t = 0; t < UP_TESTS; t++)
    begin
      take_bits(3, pick);
      k = pick % 5 + 1;
      hold_key(KEY_UP, k * REPEAT_CYCLES);
      log_steps(1, k);
      request_check();
    end

    for (int t = 0; t < DOWN_TESTS; t++)
    begin
      take_bits(3, pick);
      k = pick % 5 + 1;
      hold_key(KEY_DOWN, k * REPEAT_CYCLES);
      log_steps(-1, k);
      request_check();
    end

    // Long holds run into both bounds
    hold_key(KEY_DOWN, SAT_STEPS * REPEAT_CYCLES);
    log_steps(-1, SAT_STEPS);
    request_check();
    hold_key(KEY_UP, SAT_STEPS * REPEAT_CYCLES);
    log_steps(1, SAT_STEPS);
    request_check();

    hold_key(KEY_CLEAR, 5);
    step_log.push_back(0);
    request_check();

    for (int t = 0; t < NUM_NOTES; t++)
    begin
      take_bits(3, pick);
      check_note(pick);
    end

    // Switch 0 low keeps the tone off
    take_bits(3, pick);
    @(posedge CLK_50M);
    sw <= {3'(pick), 1'b0};
    repeat (2) @(posedge CLK_50M);
    repeat (2 * MAX_HALF)
    begin
      @(negedge CLK_50M);
      assert (audio_sample == 8'h80)
      else stop_on_failure($sformatf("ERROR at %0t: audio_sample %h while disabled",
                                     $time, audio_sample));
    end

    if (check_failures == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
verilog/organ_pkg.sv
verilog/key_input.sv
verilog/speed_control.sv
verilog/tone_generator.sv
verilog/hex_display.sv
verilog/basic_organ.sv
dv/basic_organ_tb.sv

// File: verilog/basic_organ.sv
`timescale 1ns/1ps
`default_nettype none

module basic_organ #(
  parameter int REPEAT_CYCLES = organ_pkg::REPEAT_CYCLES_DEFAULT,
  parameter int HOLD_CYCLES   = organ_pkg::HOLD_CYCLES_DEFAULT
) (
  input  wire logic                                               CLK_50M,
  input  wire logic                                               rst_n,
  input  wire logic [2:0]                                         key,
  input  wire logic [3:0]                                         sw,
  output logic [organ_pkg::NUM_DIGITS-1:0][organ_pkg::SEG_W-1:0]  hex_segments,
  output logic [organ_pkg::SAMPLE_W-1:0]                          audio_sample
);

  import organ_pkg::*;

  logic               up_step;
  logic               down_step;
  logic               clear;
  logic [COUNT_W-1:0] sample_count;

  // ============================
  // Input side
  // ============================
  key_input #(
    .REPEAT_CYCLES(REPEAT_CYCLES)
  ) u_key_input (
    .CLK_50M   (CLK_50M),
    .rst_n     (rst_n),
    .key       (key),
    .up_step   (up_step),
    .down_step (down_step),
    .clear     (clear)
  );

  // ============================
  // Processing
  // ============================
  speed_control u_speed_control (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .up_step      (up_step),
    .down_step    (down_step),
    .clear        (clear),
    .sample_count (sample_count)
  );

  tone_generator u_tone_generator (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .note_sw      (sw),
    .audio_sample (audio_sample)
  );

  // Output side
  hex_display #(
    .HOLD_CYCLES(HOLD_CYCLES)
  ) u_hex_display (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .sample_count (sample_count),
    .hex_segments (hex_segments)
  );

endmodule

`default_nettype wire

// File: verilog/hex_display.sv
`timescale 1ns/1ps
`default_nettype none

module hex_display #(
  parameter int HOLD_CYCLES = organ_pkg::HOLD_CYCLES_DEFAULT
) (
  input  wire logic                                                   CLK_50M,
  input  wire logic                                                   rst_n,
  input  wire logic [organ_pkg::COUNT_W-1:0]                          sample_count,
  output logic [organ_pkg::NUM_DIGITS-1:0][organ_pkg::SEG_W-1:0]      hex_segments
);

  import organ_pkg::*;

  localparam int CNT_W = $clog2(HOLD_CYCLES);

  logic [CNT_W-1:0]        refresh_cnt;
  logic                    refresh_wrap;
  logic [4*NUM_DIGITS-1:0] held_q;

  // Active low with bit 0 as segment a
  function automatic logic [SEG_W-1:0] seg_decode(logic [3:0] nibble);
    logic [SEG_W-1:0] seg;
    case (nibble)
      4'h0:    seg = 7'b1000000;
      4'h1:    seg = 7'b1111001;
      4'h2:    seg = 7'b0100100;
      4'h3:    seg = 7'b0110000;
      4'h4:    seg = 7'b0011001;
      4'h5:    seg = 7'b0010010;
      4'h6:    seg = 7'b0000010;
      4'h7:    seg = 7'b1111000;
      4'h8:    seg = 7'b0000000;
      4'h9:    seg = 7'b0010000;
      4'hA:    seg = 7'b0001000;
      4'hB:    seg = 7'b0000011;
      4'hC:    seg = 7'b1000110;
      4'hD:    seg = 7'b0100001;
      4'hE:    seg = 7'b0000110;
      default: seg = 7'b0001110;
    endcase
    return seg;
  endfunction

  // ============================
  // Refresh and hold
  // ============================
  assign refresh_wrap = (refresh_cnt == CNT_W'(HOLD_CYCLES - 1));

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      refresh_cnt <= '0;
      held_q      <= '0;
    end
    else if (refresh_wrap)
    begin
      refresh_cnt <= '0;
      held_q      <= (4*NUM_DIGITS)'(sample_count);
    end
    else
    begin
      refresh_cnt <= refresh_cnt + 1'b1;
    end
  end

  // Digit 0 shows the lowest nibble
  for (genvar d = 0; d < NUM_DIGITS; d++)
  begin : g_digit
    assign hex_segments[d] = seg_decode(held_q[4*d +: 4]);
  end

endmodule

`default_nettype wire

// File: verilog/key_input.sv
`timescale 1ns/1ps
`default_nettype none

module key_input #(
  parameter int REPEAT_CYCLES = organ_pkg::REPEAT_CYCLES_DEFAULT
) (
  input  wire logic       CLK_50M,
  input  wire logic       rst_n,
  // Active low up, down and clear keys from bit 0
  input  wire logic [2:0] key,
  output logic            up_step,
  output logic            down_step,
  output logic            clear
);

  import organ_pkg::*;

  localparam int CNT_W = $clog2(REPEAT_CYCLES);

  // Synchronized keys, active high
  logic [2:0]       sync_q [SYNC_STAGES];
  logic [2:0]       pressed;
  logic [CNT_W-1:0] repeat_cnt;
  logic             repeat_wrap;

  // ============================
  // Key synchronizer
  // ============================
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < SYNC_STAGES; i++)
        sync_q[i] <= '0;
    end
    else
    begin
      sync_q[0] <= ~key;
      for (int i = 1; i < SYNC_STAGES; i++)
        sync_q[i] <= sync_q[i-1];
    end
  end

  assign pressed = sync_q[SYNC_STAGES-1];

  // ============================
  // Repeat rate limiter
  // ============================
  assign repeat_wrap = (repeat_cnt == CNT_W'(REPEAT_CYCLES - 1));

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
      repeat_cnt <= '0;
    else if (repeat_wrap)
      repeat_cnt <= '0;
    else
      repeat_cnt <= repeat_cnt + 1'b1;
  end

  // One pulse per wrap while held
  assign up_step   = repeat_wrap & pressed[0];
  assign down_step = repeat_wrap & pressed[1];
  assign clear     = pressed[2];

  // A held key must not look like a continuous step to speed_control
  a_up_single_pulse : assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    up_step |=> !up_step
  );

endmodule

`default_nettype wire

// File: verilog/organ_pkg.sv
`default_nettype none

package organ_pkg;

  // ============================
  // Widths
  // ============================
  localparam int COUNT_W    = 16;
  localparam int SEG_W      = 7;
  localparam int NUM_DIGITS = 6;
  localparam int SAMPLE_W   = 8;
  localparam int HALF_W     = 16;

  // ============================
  // Speed and timing constants
  // ============================
  // Sampling count with zero offset
  localparam int DEFAULT_COUNT = 12499;
  localparam int SPEED_STEP    = 100;
  // Keeps the count between 99 and 24899
  localparam int MAX_OFFSET    = 12400;

  // Ten repeat events per second at 50 MHz
  localparam int REPEAT_CYCLES_DEFAULT = 5_000_000;
  // Display refresh at 2 Hz
  localparam int HOLD_CYCLES_DEFAULT   = 25_000_000;

  localparam int SYNC_STAGES = 2;

  // ============================
  // Notes
  // ============================
  // Index is switches 3 to 1
  typedef enum logic [2:0] {
    NOTE_DO  = 3'd0,
    NOTE_RE  = 3'd1,
    NOTE_MI  = 3'd2,
    NOTE_FA  = 3'd3,
    NOTE_SO  = 3'd4,
    NOTE_LA  = 3'd5,
    NOTE_TI  = 3'd6,
    NOTE_DO2 = 3'd7
  } note_e;

  // Half period in 50 MHz cycles
  function automatic logic [HALF_W-1:0] note_half_period(note_e note);
    logic [HALF_W-1:0] half;
    case (note)
      NOTE_DO:  half = 16'd47801;
      NOTE_RE:  half = 16'd42589;
      NOTE_MI:  half = 16'd37936;
      NOTE_FA:  half = 16'd35816;
      NOTE_SO:  half = 16'd31888;
      NOTE_LA:  half = 16'd28409;
      NOTE_TI:  half = 16'd25303;
      NOTE_DO2: half = 16'd23900;
      default:  half = 16'd47801;
    endcase
    return half;
  endfunction

endpackage

`default_nettype wire

// File: verilog/speed_control.sv
`timescale 1ns/1ps
`default_nettype none

module speed_control (
  input  wire logic                         CLK_50M,
  input  wire logic                         rst_n,
  input  wire logic                         up_step,
  input  wire logic                         down_step,
  input  wire logic                         clear,
  output logic [organ_pkg::COUNT_W-1:0]     sample_count
);

  import organ_pkg::*;

  typedef enum logic [1:0] {
    OP_HOLD,
    OP_CLEAR,
    OP_UP,
    OP_DOWN
  } speed_op_e;

  speed_op_e                  op;
  logic signed [COUNT_W-1:0]  offset_q;

  // Clear wins, then up with down cancels
  always_comb
  begin
    if (clear)
      op = OP_CLEAR;
    else if (up_step && down_step)
      op = OP_HOLD;
    else if (up_step)
      op = OP_UP;
    else if (down_step)
      op = OP_DOWN;
    else
      op = OP_HOLD;
  end

  // ============================
  // Saturating offset
  // ============================
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
      offset_q <= '0;
    else
    begin
      case (op)
        OP_CLEAR:
          offset_q <= '0;
        OP_UP:
          if (offset_q > MAX_OFFSET - SPEED_STEP)
            offset_q <= COUNT_W'(MAX_OFFSET);
          else
            offset_q <= offset_q + COUNT_W'(SPEED_STEP);
        OP_DOWN:
          if (offset_q < SPEED_STEP - MAX_OFFSET)
            offset_q <= COUNT_W'(-MAX_OFFSET);
          else
            offset_q <= offset_q - COUNT_W'(SPEED_STEP);
        default:
          offset_q <= offset_q;
      endcase
    end
  end

  // Count lags the offset by one cycle
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
      sample_count <= COUNT_W'(DEFAULT_COUNT);
    else
      sample_count <= COUNT_W'(DEFAULT_COUNT + int'(offset_q));
  end

  a_offset_bounded : assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    (offset_q <= MAX_OFFSET) && (offset_q >= -MAX_OFFSET)
  );

endmodule

`default_nettype wire

// File: verilog/tone_generator.sv
`timescale 1ns/1ps
`default_nettype none

module tone_generator (
  input  wire logic                         CLK_50M,
  input  wire logic                         rst_n,
  // Bits 3 to 1 pick the note and bit 0 enables
  input  wire logic [3:0]                   note_sw,
  output logic [organ_pkg::SAMPLE_W-1:0]    audio_sample
);

  import organ_pkg::*;

  logic [3:0]         sw_q;
  logic               sw_change;
  note_e              note;
  logic               enable;
  logic [HALF_W-1:0]  half;
  logic [HALF_W-1:0]  div_cnt;
  logic               tone;

  // ============================
  // Switch decode
  // ============================
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
      sw_q <= '0;
    else
      sw_q <= note_sw;
  end

  assign sw_change = (note_sw != sw_q);
  assign note      = note_e'(sw_q[3:1]);
  assign enable    = sw_q[0];
  assign half      = note_half_period(note);

  // ============================
  // Square wave divider
  // ============================
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      div_cnt <= '0;
      tone    <= 1'b0;
    end
    else if (sw_change || !enable)
    begin
      // Restart low on any switch change
      div_cnt <= '0;
      tone    <= 1'b0;
    end
    else if (div_cnt == half - HALF_W'(1))
    begin
      div_cnt <= '0;
      tone    <= ~tone;
    end
    else
    begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // Signed sample is 0x80 low and 0x7F high
  assign audio_sample = {~tone, {(SAMPLE_W-1){tone}}};

  a_div_in_range : assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    div_cnt < half
  );

endmodule

`default_nettype wire
